/* hdl/snes_cart_config.svh */
`ifndef SNES_CART_CONFIG_SVH
`define SNES_CART_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////////////////////

// Console address bus, full 24-bit space
`define SNES_ADDR_W 24

// PSRAM data bus, two byte lanes
`define ROM_DATA_W 16

////////////////////////////////////////////////////////////////////////////
// Access timing in CLK2 cycles
////////////////////////////////////////////////////////////////////////////

`define ROM_CYCLE_LEN 6       // Countdown load for a PSRAM access
`define COP_CYCLE_LEN 16      // Coprocessor reads take the longer path

// Console clock low this long means no console, about 1 ms
`define SNES_DEAD_TIMEOUT 80000

// Sampling shift register length for console inputs
`define SYNC_DEPTH 8

`endif

/* hdl/rom_bus_pkg.sv */
`include "snes_cart_config.svh"

package rom_bus_pkg;

  // MCU byte request, read or write
  typedef struct packed {
    logic                    rd;
    logic                    wr;
    logic [`SNES_ADDR_W-1:0] addr;
    logic [7:0]              data;
  } mcu_rq_t;

  // Context engine write, byte or word
  typedef struct packed {
    logic [`SNES_ADDR_W-1:0] addr;
    logic [15:0]             data;
    logic                    word;
  } ctx_rq_t;

  // Coprocessor byte read
  typedef struct packed {
    logic [`SNES_ADDR_W-1:0] addr;
  } cop_rq_t;

  // Filtered console events
  typedef struct packed {
    logic rd_start;
    logic rd_end;
    logic wr_end;
    logic cycle_start;
    logic cycle_end;
    logic reset_strobe;    // Console came back after a dead period
    logic dead;            // Level, console clock stopped
  } snes_strobes_t;

  typedef enum logic [2:0] {
    arb_idle,
    arb_mcu_rd,
    arb_mcu_wr,
    arb_ctx_wr,
    arb_cop_rd,
    arb_end
  } arb_state_t;

  // Even address sits on the upper lane
  function automatic logic [7:0] rom_byte_sel(input logic [`ROM_DATA_W-1:0] din,
                                              input logic                   a0);
    return a0 ? din[7:0] : din[15:8];
  endfunction

endpackage

/* hdl/snes_bus_sync.sv */
`timescale 1ns/1ps
`include "snes_cart_config.svh"

module snes_bus_sync
  import rom_bus_pkg::*;
(
  input  logic                    CLK2,
  input  logic                    reset,
  input  logic                    snes_read_in,
  input  logic                    snes_write_in,
  input  logic                    snes_cpu_clk_in,
  input  logic                    snes_romsel_in,
  input  logic [`SNES_ADDR_W-1:0] snes_addr_in,
  output snes_strobes_t           strobes,
  output logic                    snes_read,
  output logic [`SNES_ADDR_W-1:0] snes_addr,
  output logic                    free_slot,
  input  logic                    rom_hit
);

  localparam int D = `SYNC_DEPTH;
  localparam int DEAD_W = $clog2(`SNES_DEAD_TIMEOUT) + 2;
  localparam logic [DEAD_W-1:0] DEAD_LIMIT = DEAD_W'(`SNES_DEAD_TIMEOUT);

  logic [D-1:0] read_r;
  logic [D-1:0] write_r;
  logic [D-1:0] clk_r;
  logic [D-1:0] romsel_r;
  logic [`SNES_ADDR_W-1:0] addr_r [D-1];

  logic [DEAD_W-1:0] dead_cnt;
  logic dead_r;
  logic reset_strb;
  logic free_strobe;
  logic romsel_late;

  ////////////////////////////////////////////////////////////////////////////
  // Input sampling
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      read_r   <= '1;            // Bus idle
      write_r  <= '1;
      romsel_r <= '1;
      clk_r    <= '0;
    end else begin
      read_r   <= {read_r[D-2:0], snes_read_in};
      write_r  <= {write_r[D-2:0], snes_write_in};
      romsel_r <= {romsel_r[D-2:0], snes_romsel_in};
      clk_r    <= {clk_r[D-2:0], snes_cpu_clk_in};
    end
  end

  // Address pipeline, lines up with the filtered strobes
  always_ff @(posedge CLK2) begin
    addr_r[0] <= snes_addr_in;
    for (int i = 1; i < D - 1; i++) begin
      addr_r[i] <= addr_r[i-1];
    end
  end

  assign snes_addr = addr_r[D-2] & addr_r[D-3];
  assign snes_read = read_r[2] & read_r[1];
  assign romsel_late = romsel_r[D-4] & romsel_r[D-5];

  ////////////////////////////////////////////////////////////////////////////
  // Edge strobes, pairs of samples ANDed or ORed to drop single-cycle glitches
  ////////////////////////////////////////////////////////////////////////////

  assign strobes.rd_start =
    ((read_r[D-2:1] | read_r[D-1:2]) == {{(D-4){1'b1}}, 2'b00});
  assign strobes.rd_end =
    ((read_r[D-2:1] & read_r[D-1:2]) == {{(D-3){1'b0}}, 1'b1});
  assign strobes.wr_end =
    ((write_r[D-2:1] & write_r[D-1:2]) == {{(D-3){1'b0}}, 1'b1});
  assign strobes.cycle_start =
    ((clk_r[D-1:2] & clk_r[D-2:1]) == {{(D-4){1'b0}}, 2'b11});
  assign strobes.cycle_end =
    ((clk_r[D-1:2] | clk_r[D-2:1]) == {3'b111, {(D-5){1'b0}}});
  assign strobes.reset_strobe = reset_strb;
  assign strobes.dead = dead_r;

  // Non-ROM cycle leaves the PSRAM free right after cycle start
  always_ff @(posedge CLK2) begin
    if (reset) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= strobes.cycle_start & ~(rom_hit | ~romsel_late);
    end
  end

  assign free_slot = strobes.cycle_end | free_strobe;

  ////////////////////////////////////////////////////////////////////////////
  // Dead console detection
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset || clk_r[1]) begin
      dead_cnt <= '0;
    end else if (dead_cnt <= DEAD_LIMIT) begin
      dead_cnt <= dead_cnt + 1'b1;     // Saturates past the limit
    end
  end

  always_ff @(posedge CLK2) begin
    if (reset) begin
      dead_r     <= 1'b1;              // No console seen yet
      reset_strb <= 1'b0;
    end else begin
      reset_strb <= 1'b0;
      if (clk_r[1]) begin
        dead_r <= 1'b0;
        if (dead_r) reset_strb <= 1'b1;
      end else if (dead_cnt > DEAD_LIMIT) begin
        dead_r <= 1'b1;
      end
    end
  end

endmodule

/* hdl/rom_rq_slot.sv */
`timescale 1ns/1ps

module rom_rq_slot #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     CLK2,
  input  logic     reset,
  input  logic     rq,
  input  logic     done,
  input  payload_t rq_data,
  output logic     pending,
  output logic     rdy,
  output payload_t held
);

  logic accept;

  // Strobe while busy is dropped
  assign accept = rq & ~pending;

  always_ff @(posedge CLK2) begin
    if (reset) begin
      pending <= 1'b0;
      rdy     <= 1'b1;
    end else if (accept) begin
      pending <= 1'b1;
      rdy     <= 1'b0;
    end else if (done) begin
      pending <= 1'b0;   // Arbiter end state
      rdy     <= 1'b1;
    end
  end

  // Payload stays put until the access is done
  always_ff @(posedge CLK2) begin
    if (accept) begin
      held <= rq_data;
    end
  end

endmodule

/* hdl/rom_arbiter.sv */
`timescale 1ns/1ps
`include "snes_cart_config.svh"

module rom_arbiter
  import rom_bus_pkg::*;
(
  input  logic                    CLK2,
  input  logic                    reset,
  input  snes_strobes_t           strobes,
  input  logic                    free_slot,
  input  logic                    cop_active,
  input  logic                    mcu_pend,
  input  logic                    ctx_pend,
  input  logic                    cop_pend,
  input  mcu_rq_t                 mcu,
  input  ctx_rq_t                 ctx,
  input  cop_rq_t                 cop,
  input  logic [`SNES_ADDR_W-1:0] snes_map_addr,
  input  logic [`ROM_DATA_W-1:0]  rom_din,
  output logic                    mcu_done,
  output logic                    ctx_done,
  output logic                    cop_done,
  output logic [7:0]              mcu_rdata,
  output logic [7:0]              cop_rdata,
  output logic [`SNES_ADDR_W-2:0] rom_addr,
  output logic                    rom_addr0,
  output logic                    rom_we,
  output logic                    rom_bhe,
  output logic                    rom_ble,
  output logic                    rom_dout_en,
  output logic [`ROM_DATA_W-1:0]  rom_dout
);

  localparam int DLY_W = $clog2(`COP_CYCLE_LEN + 1);

  arb_state_t state;
  logic [DLY_W-1:0] delay;
  logic [`SNES_ADDR_W-1:0] snes_addr_r;
  logic [`SNES_ADDR_W-1:0] acc_addr;
  logic [7:0] rom_byte;
  logic [7:0] lane_hi;
  logic [7:0] lane_lo;
  logic ctx_wr_hit;
  logic mcu_wr_hit;
  logic word_wr;
  logic last_cycle;

  assign last_cycle = (delay == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Bus ownership FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      state    <= arb_idle;
      delay    <= '0;
      mcu_done <= 1'b0;
      ctx_done <= 1'b0;
      cop_done <= 1'b0;
    end else if (strobes.reset_strobe) begin
      // Console just came alive, restart whatever was running
      state    <= arb_idle;
      mcu_done <= 1'b0;
      ctx_done <= 1'b0;
      cop_done <= 1'b0;
    end else begin
      mcu_done <= 1'b0;
      ctx_done <= 1'b0;
      cop_done <= 1'b0;
      case (state)
        arb_idle: begin
          if (cop_active && cop_pend) begin
            state <= arb_cop_rd;     // No slot needed
            delay <= DLY_W'(`COP_CYCLE_LEN);
          end else if (free_slot || strobes.dead) begin
            if (ctx_pend) begin
              state <= arb_ctx_wr;
              delay <= DLY_W'(`ROM_CYCLE_LEN);
            end else if (mcu_pend && mcu.rd) begin
              state <= arb_mcu_rd;
              delay <= DLY_W'(`ROM_CYCLE_LEN);
            end else if (mcu_pend && mcu.wr) begin
              state <= arb_mcu_wr;
              delay <= DLY_W'(`ROM_CYCLE_LEN);
            end
          end
        end
        arb_mcu_rd, arb_mcu_wr, arb_ctx_wr, arb_cop_rd: begin
          delay <= delay - 1'b1;
          if (last_cycle) begin
            state    <= arb_end;
            mcu_done <= (state == arb_mcu_rd) || (state == arb_mcu_wr);
            ctx_done <= (state == arb_ctx_wr);
            cop_done <= (state == arb_cop_rd);
          end
        end
        default: state <= arb_idle;   // arb_end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address and read data
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    snes_addr_r <= snes_map_addr;
  end

  always_comb begin
    case (state)
      arb_ctx_wr:             acc_addr = ctx.addr;
      arb_mcu_rd, arb_mcu_wr: acc_addr = mcu.addr;
      arb_cop_rd:             acc_addr = cop.addr;
      default:                acc_addr = snes_addr_r;   // Console owns the bus
    endcase
  end

  assign rom_addr  = acc_addr[`SNES_ADDR_W-1:1];
  assign rom_addr0 = acc_addr[0];
  assign rom_byte  = rom_byte_sel(rom_din, rom_addr0);

  // Sample on the last held cycle, PSRAM has settled by then
  always_ff @(posedge CLK2) begin
    if (last_cycle && state == arb_mcu_rd) mcu_rdata <= rom_byte;
    if (last_cycle && state == arb_cop_rd) cop_rdata <= rom_byte;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write lanes and strobes
  ////////////////////////////////////////////////////////////////////////////

  assign ctx_wr_hit = (state == arb_ctx_wr);
  assign mcu_wr_hit = (state == arb_mcu_wr);
  assign word_wr    = ctx_wr_hit & ctx.word;

  // Word write puts the high byte at the even address
  // Byte writes carry the low byte on whichever lane bit 0 selects
  assign lane_hi = ctx_wr_hit ? (ctx.word ? ctx.data[15:8] : ctx.data[7:0]) : mcu.data;
  assign lane_lo = ctx_wr_hit ? ctx.data[7:0] : mcu.data;

  assign rom_dout    = {lane_hi, lane_lo};
  assign rom_dout_en = ctx_wr_hit | mcu_wr_hit;
  assign rom_we      = ~(ctx_wr_hit | mcu_wr_hit);   // Active low

  // Byte enables active low, both lanes on a word write
  assign rom_bhe = rom_addr0 & ~word_wr;
  assign rom_ble = ~rom_addr0 & ~word_wr;

endmodule

/* hdl/snes_rom_top.sv */
`timescale 1ns/1ps
`include "snes_cart_config.svh"

module snes_rom_top
  import rom_bus_pkg::*;
(
  input  logic                    CLK2,
  input  logic                    reset,
  // Console bus
  input  logic                    snes_read_in,
  input  logic                    snes_write_in,
  input  logic                    snes_cpu_clk_in,
  input  logic                    snes_romsel_in,
  input  logic [`SNES_ADDR_W-1:0] snes_addr_in,
  input  logic [`SNES_ADDR_W-1:0] rom_mask,
  output logic [7:0]              snes_data_out,
  output logic                    snes_data_oe,
  // MCU
  input  logic                    mcu_rrq,
  input  logic                    mcu_wrq,
  input  logic [`SNES_ADDR_W-1:0] mcu_addr,
  input  logic [7:0]              mcu_wdata,
  output logic                    mcu_rdy,
  output logic [7:0]              mcu_rdata,
  // Context engine
  input  logic                    ctx_wrq,
  input  logic [`SNES_ADDR_W-1:0] ctx_addr,
  input  logic [15:0]             ctx_data,
  input  logic                    ctx_word,
  output logic                    ctx_rdy,
  // Coprocessor
  input  logic                    cop_active,
  input  logic                    cop_rrq,
  input  logic [`SNES_ADDR_W-1:0] cop_addr,
  output logic                    cop_rdy,
  output logic [7:0]              cop_rdata,
  // PSRAM
  output logic [`SNES_ADDR_W-2:0] rom_addr,
  output logic                    rom_addr0,
  output logic                    rom_we,
  output logic                    rom_bhe,
  output logic                    rom_ble,
  output logic                    rom_dout_en,
  output logic [`ROM_DATA_W-1:0]  rom_dout,
  input  logic [`ROM_DATA_W-1:0]  rom_din
);

  snes_strobes_t strobes;
  logic snes_read;
  logic [`SNES_ADDR_W-1:0] snes_addr;
  logic [`SNES_ADDR_W-1:0] snes_map_addr;
  logic free_slot;
  logic rom_hit;

  mcu_rq_t mcu_in;
  mcu_rq_t mcu_held;
  ctx_rq_t ctx_in;
  ctx_rq_t ctx_held;
  cop_rq_t cop_in;
  cop_rq_t cop_held;
  logic mcu_pend;
  logic ctx_pend;
  logic cop_pend;
  logic mcu_done;
  logic ctx_done;
  logic cop_done;

  assign rom_hit       = ~snes_romsel_in;        // Early select, feeds the free slot too
  assign snes_map_addr = snes_addr & rom_mask;

  snes_bus_sync u_sync (
    .CLK2, .reset,
    .snes_read_in, .snes_write_in, .snes_cpu_clk_in, .snes_romsel_in, .snes_addr_in,
    .strobes, .snes_read, .snes_addr, .free_slot, .rom_hit
  );

  // Read wins if both MCU strobes arrive together
  assign mcu_in.rd   = mcu_rrq;
  assign mcu_in.wr   = mcu_wrq & ~mcu_rrq;
  assign mcu_in.addr = mcu_addr;
  assign mcu_in.data = mcu_wdata;

  assign ctx_in.addr = ctx_addr;
  assign ctx_in.data = ctx_data;
  assign ctx_in.word = ctx_word;

  assign cop_in.addr = cop_addr;

  rom_rq_slot #(.payload_t(mcu_rq_t)) u_mcu_slot (
    .CLK2, .reset, .rq(mcu_rrq | mcu_wrq), .done(mcu_done), .rq_data(mcu_in),
    .pending(mcu_pend), .rdy(mcu_rdy), .held(mcu_held)
  );

  rom_rq_slot #(.payload_t(ctx_rq_t)) u_ctx_slot (
    .CLK2, .reset, .rq(ctx_wrq), .done(ctx_done), .rq_data(ctx_in),
    .pending(ctx_pend), .rdy(ctx_rdy), .held(ctx_held)
  );

  rom_rq_slot #(.payload_t(cop_rq_t)) u_cop_slot (
    .CLK2, .reset, .rq(cop_rrq), .done(cop_done), .rq_data(cop_in),
    .pending(cop_pend), .rdy(cop_rdy), .held(cop_held)
  );

  rom_arbiter u_arb (
    .CLK2, .reset, .strobes, .free_slot, .cop_active,
    .mcu_pend, .ctx_pend, .cop_pend,
    .mcu(mcu_held), .ctx(ctx_held), .cop(cop_held),
    .snes_map_addr, .rom_din,
    .mcu_done, .ctx_done, .cop_done, .mcu_rdata, .cop_rdata,
    .rom_addr, .rom_addr0, .rom_we, .rom_bhe, .rom_ble, .rom_dout_en, .rom_dout
  );

  ////////////////////////////////////////////////////////////////////////////
  // Console data out
  ////////////////////////////////////////////////////////////////////////////

  assign snes_data_out = rom_byte_sel(rom_din, rom_addr0);
  assign snes_data_oe  = ~snes_read & rom_hit;   // Only while reading ROM

endmodule

/* sim/rom_arbiter_checker.sv */
`timescale 1ns/1ps

module rom_arbiter_checker
  import rom_bus_pkg::*;
(
  input logic          CLK2,
  input logic          reset,
  input snes_strobes_t strobes,
  input mcu_rq_t       mcu,
  input logic          rom_we,
  input logic          rom_dout_en,
  input logic          mcu_done,
  input logic          ctx_done,
  input logic          cop_done
);

  ////////////////////////////////////////////////////////////////////////////
  // PSRAM strobes
  ////////////////////////////////////////////////////////////////////////////

  // Write window closes with its done pulse unless the console aborted it
  we_ends_with_write_done: assert property (@(posedge CLK2) disable iff (reset)
    $rose(rom_we) && !$past(strobes.reset_strobe) |-> mcu_done || ctx_done)
    else $error("rom_we released without a write done");

  write_bus_driven: assert property (@(posedge CLK2) disable iff (reset)
    ctx_done || (mcu_done && !mcu.rd) |-> $past(!rom_we && rom_dout_en))
    else $error("write finished without driving the PSRAM bus");

  // Reads leave the data bus to the PSRAM
  read_bus_released: assert property (@(posedge CLK2) disable iff (reset)
    cop_done || (mcu_done && mcu.rd) |-> $past(rom_we && !rom_dout_en))
    else $error("PSRAM written or driven during a read");

  // Done pulses, one cycle each and never two at once
  done_onehot: assert property (@(posedge CLK2) disable iff (reset)
    $onehot0({mcu_done, ctx_done, cop_done}))
    else $error("more than one done pulse in a cycle");

  mcu_done_pulse: assert property (@(posedge CLK2) disable iff (reset)
    mcu_done |=> !mcu_done)
    else $error("mcu_done longer than one cycle");

  ctx_done_pulse: assert property (@(posedge CLK2) disable iff (reset)
    ctx_done |=> !ctx_done)
    else $error("ctx_done longer than one cycle");

  cop_done_pulse: assert property (@(posedge CLK2) disable iff (reset)
    cop_done |=> !cop_done)
    else $error("cop_done longer than one cycle");

endmodule

bind rom_arbiter rom_arbiter_checker u_arb_chk (
  .CLK2, .reset, .strobes, .mcu, .rom_we, .rom_dout_en, .mcu_done, .ctx_done, .cop_done
);

/* sim/tb_snes_rom.sv */
`timescale 1ns/1ps
`include "snes_cart_config.svh"

module tb_snes_rom;

  localparam int N_MCU = 24;
  localparam int N_CTX = 16;
  localparam int N_PRI = 6;
  localparam int N_COP = 8;
  localparam int N_CON = 12;
  localparam int CON_HOLD = 16;       // Console read low time in CLK2 cycles
  localparam int OP_CYCLES = 40;      // One access with a slot wait, generous
  localparam int MAX_CYCLES = (2 * N_MCU + 3 * N_CTX + 2 * N_PRI + 2 * N_COP
                               + 2 * N_CON) * OP_CYCLES + N_CON * (CON_HOLD + 4) + 500;

  logic CLK2;
  logic reset;
  logic snes_read_in;
  logic snes_write_in;
  logic snes_cpu_clk_in = 1'b0;
  logic snes_romsel_in;
  logic [`SNES_ADDR_W-1:0] snes_addr_in;
  logic [`SNES_ADDR_W-1:0] rom_mask;
  logic [7:0] snes_data_out;
  logic snes_data_oe;
  logic mcu_rrq;
  logic mcu_wrq;
  logic [`SNES_ADDR_W-1:0] mcu_addr;
  logic [7:0] mcu_wdata;
  logic mcu_rdy;
  logic [7:0] mcu_rdata;
  logic ctx_wrq;
  logic [`SNES_ADDR_W-1:0] ctx_addr;
  logic [15:0] ctx_data;
  logic ctx_word;
  logic ctx_rdy;
  logic cop_active;
  logic cop_rrq;
  logic [`SNES_ADDR_W-1:0] cop_addr;
  logic cop_rdy;
  logic [7:0] cop_rdata;
  logic [`SNES_ADDR_W-2:0] rom_addr;
  logic rom_addr0;
  logic rom_we;
  logic rom_bhe;
  logic rom_ble;
  logic rom_dout_en;
  logic [`ROM_DATA_W-1:0] rom_dout;
  logic [`ROM_DATA_W-1:0] rom_din;

  logic [15:0] psram [0:65535];
  logic [7:0] exp_mem [0:131071];     // Expected memory, one entry per byte
  logic [31:0] rng = 32'd62265;
  logic console_on = 1'b0;
  logic [2:0] cpu_div = 3'd0;
  int errors = 0;
  int checks = 0;
  int cycles = 0;

  snes_rom_top uut (.*);

  initial begin
    CLK2 = 1'b0;
    forever #4 CLK2 = ~CLK2;
  end

  ////////////////////////////////////////////////////////////////////////////
  // PSRAM model, console clock and watchdog
  ////////////////////////////////////////////////////////////////////////////

  assign rom_din = psram[rom_addr[15:0]];

  always @(posedge CLK2) begin
    // FPGA drives the PSRAM data bus exactly while it writes
    if (!reset) check_value("psram data drive", 32'(!rom_we), 32'(rom_dout_en));
    if (!rom_we) begin
      if (!rom_bhe) psram[rom_addr[15:0]][15:8] <= rom_dout[15:8];   // Even byte
      if (!rom_ble) psram[rom_addr[15:0]][7:0] <= rom_dout[7:0];
    end
  end

  // Console clock at 12 CLK2 cycles per period
  always @(posedge CLK2) begin
    if (console_on) begin
      if (cpu_div == 3'd5) begin
        cpu_div <= 3'd0;
        snes_cpu_clk_in <= ~snes_cpu_clk_in;
      end else begin
        cpu_div <= cpu_div + 3'd1;
      end
    end
  end

  always @(posedge CLK2) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the DUT did not answer within %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_next();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic logic [23:0] rand_addr();
    logic [31:0] r;
    r = rand_next();
    return {7'd0, r[16:0]};           // Stays inside the modeled 128K bytes
  endfunction

  function automatic logic [15:0] fill_word(input int i);
    logic [15:0] a;
    a = 16'(i);
    return (a * 16'd40503) ^ {a[7:0], a[15:8]} ^ 16'hc3a5;
  endfunction

  function automatic void model_ctx_write(input logic [23:0] addr, input logic [15:0] data,
                                          input logic word);
    if (word) begin
      exp_mem[{addr[16:1], 1'b0}] = data[15:8];
      exp_mem[{addr[16:1], 1'b1}] = data[7:0];
    end else begin
      exp_mem[addr[16:0]] = data[7:0];
    end
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  // One MCU byte access, returns once mcu_rdy is back
  task automatic mcu_access(input logic wr, input logic [23:0] addr, input logic [7:0] data);
    int low_cycles;
    low_cycles = 0;
    @(posedge CLK2);
    mcu_rrq   <= ~wr;
    mcu_wrq   <= wr;
    mcu_addr  <= addr;
    mcu_wdata <= data;
    @(posedge CLK2);
    mcu_rrq <= 1'b0;
    mcu_wrq <= 1'b0;
    @(negedge CLK2);
    while (!mcu_rdy) begin
      low_cycles++;
      @(negedge CLK2);
    end
    check_value("mcu ready low time", 32'(1), 32'(low_cycles >= 9));
  endtask

  task automatic mcu_write(input logic [23:0] addr, input logic [7:0] data);
    mcu_access(1'b1, addr, data);
    exp_mem[addr[16:0]] = data;
  endtask

  task automatic mcu_read_check(input string name, input logic [23:0] addr);
    mcu_access(1'b0, addr, 8'h00);
    check_value(name, 32'(exp_mem[addr[16:0]]), 32'(mcu_rdata));
  endtask

  task automatic ctx_write(input logic [23:0] addr, input logic [15:0] data, input logic word);
    @(posedge CLK2);
    ctx_wrq  <= 1'b1;
    ctx_addr <= addr;
    ctx_data <= data;
    ctx_word <= word;
    @(posedge CLK2);
    ctx_wrq <= 1'b0;
    @(negedge CLK2);
    while (!ctx_rdy) @(negedge CLK2);
    model_ctx_write(addr, data, word);
  endtask

  // Context and MCU write in the same cycle
  task automatic priority_pair(input logic [23:0] caddr, input logic [15:0] cdata,
                               input logic cword, input logic [23:0] maddr,
                               input logic [7:0] mdata);
    @(posedge CLK2);
    ctx_wrq   <= 1'b1;
    ctx_addr  <= caddr;
    ctx_data  <= cdata;
    ctx_word  <= cword;
    mcu_wrq   <= 1'b1;
    mcu_addr  <= maddr;
    mcu_wdata <= mdata;
    @(posedge CLK2);
    ctx_wrq <= 1'b0;
    mcu_wrq <= 1'b0;
    @(negedge CLK2);
    while (!ctx_rdy && !mcu_rdy) @(negedge CLK2);
    check_value("priority ctx ready first", 32'(1), 32'(ctx_rdy));
    check_value("priority mcu still busy", 32'(0), 32'(mcu_rdy));
    while (!mcu_rdy) @(negedge CLK2);
    model_ctx_write(caddr, cdata, cword);
    exp_mem[maddr[16:0]] = mdata;
  endtask

  // Coprocessor read with an MCU read waiting behind it
  task automatic cop_with_mcu(input logic [23:0] caddr, input logic [23:0] maddr);
    @(posedge CLK2);
    cop_rrq  <= 1'b1;
    cop_addr <= caddr;
    mcu_rrq  <= 1'b1;
    mcu_addr <= maddr;
    @(posedge CLK2);
    cop_rrq <= 1'b0;
    mcu_rrq <= 1'b0;
    @(negedge CLK2);
    while (!cop_rdy && !mcu_rdy) @(negedge CLK2);
    check_value("cop ready first", 32'(1), 32'(cop_rdy));
    check_value("mcu waits for cop", 32'(0), 32'(mcu_rdy));
    check_value("cop read data", 32'(exp_mem[caddr[16:0]]), 32'(cop_rdata));
    while (!mcu_rdy) @(negedge CLK2);
    check_value("mcu read after cop", 32'(exp_mem[maddr[16:0]]), 32'(mcu_rdata));
  endtask

  task automatic console_read(input logic [23:0] addr);
    logic [23:0] maddr;
    maddr = addr & rom_mask;
    @(posedge CLK2);
    snes_addr_in   <= addr;
    snes_romsel_in <= 1'b0;
    snes_read_in   <= 1'b0;
    repeat (CON_HOLD) @(posedge CLK2);
    @(negedge CLK2);                  // Read still low here
    check_value("console data oe", 32'(1), 32'(snes_data_oe));
    check_value("console rom_addr0", 32'(maddr[0]), 32'(rom_addr0));
    check_value("console read data", 32'(exp_mem[maddr[16:0]]), 32'(snes_data_out));
    @(posedge CLK2);
    snes_read_in   <= 1'b1;
    snes_romsel_in <= 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [23:0] a;
    logic [15:0] w;
    logic [23:0] wr_addrs [N_MCU];

    reset          = 1'b1;
    snes_read_in   = 1'b1;
    snes_write_in  = 1'b1;
    snes_romsel_in = 1'b1;
    snes_addr_in   = '0;
    rom_mask       = 24'h00ffff;
    mcu_rrq        = 1'b0;
    mcu_wrq        = 1'b0;
    mcu_addr       = '0;
    mcu_wdata      = '0;
    ctx_wrq        = 1'b0;
    ctx_addr       = '0;
    ctx_data       = '0;
    ctx_word       = 1'b0;
    cop_active     = 1'b0;
    cop_rrq        = 1'b0;
    cop_addr       = '0;
    for (int i = 0; i < 65536; i++) begin
      w                  = fill_word(i);
      psram[i]           = w;
      exp_mem[2 * i]     = w[15:8];   // Upper lane is the even byte
      exp_mem[2 * i + 1] = w[7:0];
    end

    repeat (3) @(posedge CLK2);
    reset <= 1'b0;
    @(negedge CLK2);
    check_value("reset mcu_rdy", 32'(1), 32'(mcu_rdy));
    check_value("reset ctx_rdy", 32'(1), 32'(ctx_rdy));
    check_value("reset cop_rdy", 32'(1), 32'(cop_rdy));
    check_value("reset rom_we", 32'(1), 32'(rom_we));
    check_value("reset snes_data_oe", 32'(0), 32'(snes_data_oe));

    // Console clock stopped, arbiter grants without slots
    for (int i = 0; i < N_MCU; i++) begin
      wr_addrs[i] = rand_addr();
      r = rand_next();
      mcu_write(wr_addrs[i], r[7:0]);
    end
    for (int i = 0; i < N_MCU; i++) begin
      mcu_read_check("mcu read back", wr_addrs[i]);
    end

    for (int i = 0; i < N_CTX; i++) begin
      a = rand_addr();
      r = rand_next();
      ctx_write(a, r[15:0], r[16]);
      mcu_read_check("ctx even byte", {a[23:1], 1'b0});
      mcu_read_check("ctx odd byte", {a[23:1], 1'b1});
    end

    for (int i = 0; i < N_PRI; i++) begin
      a = rand_addr();
      r = rand_next();
      priority_pair(a, r[15:0], r[16], rand_addr(), r[31:24]);
    end

    @(posedge CLK2);
    cop_active <= 1'b1;
    for (int i = 0; i < N_COP; i++) begin
      a = rand_addr();
      cop_with_mcu(a, rand_addr());
    end
    @(posedge CLK2);
    cop_active <= 1'b0;

    // Bring the console to life, then mix console reads and MCU traffic
    @(posedge CLK2);
    console_on <= 1'b1;
    repeat (40) @(posedge CLK2);
    @(negedge CLK2);
    check_value("console alive", 32'(0), 32'(uut.strobes.dead));
    for (int i = 0; i < N_CON; i++) begin
      r = rand_next();
      console_read(r[23:0]);
      a = rand_addr();
      r = rand_next();
      mcu_write(a, r[7:0]);
      mcu_read_check("mcu between console reads", a);
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+hdl
hdl/rom_bus_pkg.sv
hdl/snes_bus_sync.sv
hdl/rom_rq_slot.sv
hdl/rom_arbiter.sv
hdl/snes_rom_top.sv
sim/rom_arbiter_checker.sv
sim/tb_snes_rom.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_snes_rom
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TB PASSED

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard hdl/*.sv hdl/*.svh sim/*.sv) $(FILELIST)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
